// ==== Bender.yml ====
package:
  name: dcache

sources:
  - verilog/dcache_pkg.sv
  - verilog/dcache_merge.sv
  - verilog/dcache_data_array.sv
  - verilog/dcache_tag_array.sv
  - verilog/dcache_ctrl.sv
  - verilog/dcache_top.sv
  - target: simulation
    files:
      - sim/dcache_sva.sv
      - sim/dcache_tb.sv

// ==== dcache.f ====
verilog/dcache_pkg.sv
verilog/dcache_merge.sv
verilog/dcache_data_array.sv
verilog/dcache_tag_array.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
sim/dcache_sva.sv
sim/dcache_tb.sv

// ==== sim/dcache_sva.sv ====
`timescale 1ns/10ps

module dcache_sva
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  p_ready_i,
    input  logic                  m_strobe_i,
    input  logic                  m_ready_i,
    input  dcache_pkg::mem_req_t  m_req_i
);

    localparam int LINE_LSB = dcache_pkg::BYTE_BITS + dcache_pkg::OFFSET_BITS;

    // Assertion failures so far
    int fail_count = 0;

    // ========================================================================
    // Port protocol
    // ========================================================================

    // Memory request held until the answer
    a_strobe_held : assert property (@(posedge clk_i) disable iff (rst_i)
        m_strobe_i && !m_ready_i |=> m_strobe_i && $stable(m_req_i))
        else
        begin
            fail_count = fail_count + 1;
            $error("m_strobe_o or m_req_o changed before m_ready_i");
        end

    // Processor ready is a single pulse
    a_ready_pulse : assert property (@(posedge clk_i) disable iff (rst_i)
        p_ready_i |=> !p_ready_i)
        else
        begin
            fail_count = fail_count + 1;
            $error("p_ready_o high on two cycles in a row");
        end

    // Line-aligned memory address
    a_line_aligned : assert property (@(posedge clk_i) disable iff (rst_i)
        m_strobe_i |-> m_req_i.addr[LINE_LSB-1:0] == '0)
        else
        begin
            fail_count = fail_count + 1;
            $error("m_req_o.addr not line aligned");
        end

endmodule

bind dcache_top dcache_sva u_sva (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .p_ready_i  (p_ready_o),
    .m_strobe_i (m_strobe_o),
    .m_ready_i  (m_ready_i),
    .m_req_i    (m_req_o)
);

// ==== sim/dcache_tb.sv ====
`timescale 1ns/10ps

module dcache_tb;

    // ========================================================================
    // Run limits and stimulus format
    // ========================================================================

    localparam int N_ENTRIES   = 20;
    localparam int CYCLE_LIMIT = 20 * N_ENTRIES + 50;
    localparam int MEM_BYTES   = 4096;
    localparam int LINE_BYTES  = dcache_pkg::LINE_BITS / 8;

    // One table row with the expected lookup result in hit
    typedef struct packed {
        logic                 rw;
        dcache_pkg::be_t      be;
        dcache_pkg::addr_t    addr;
        dcache_pkg::word_t    wdata;
        logic                 hit;
    } stim_t;

    logic                  clk_i;
    logic                  rst_i;
    logic                  p_strobe_i;
    dcache_pkg::cpu_req_t  p_req_i;
    dcache_pkg::word_t     p_rdata_o;
    logic                  p_ready_o;
    dcache_pkg::mem_req_t  m_req_o;
    logic                  m_strobe_o;
    dcache_pkg::line_t     m_rdata_i;
    logic                  m_ready_i;

    stim_t                 stim [N_ENTRIES];
    // Processor view and memory view of the same bytes
    logic [7:0]            gold_bytes [MEM_BYTES];
    logic [7:0]            mem_bytes [MEM_BYTES];
    // Memory transfers seen during the current request
    logic                  log_rw [$];
    dcache_pkg::addr_t     log_addr [$];
    dcache_pkg::line_t     log_data [$];
    // FIFO model with the oldest line of a set in slot 0
    dcache_pkg::tag_t      way_tag [dcache_pkg::N_SETS][dcache_pkg::N_WAYS];
    logic                  way_dirty [dcache_pkg::N_SETS][dcache_pkg::N_WAYS];
    int                    way_count [dcache_pkg::N_SETS];
    int                    cycle_count;
    int                    check_count;
    int                    error_count;

    dcache_top DUT (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .p_strobe_i (p_strobe_i),
        .p_req_i    (p_req_i),
        .p_rdata_o  (p_rdata_o),
        .p_ready_o  (p_ready_o),
        .m_req_o    (m_req_o),
        .m_strobe_o (m_strobe_o),
        .m_rdata_i  (m_rdata_i),
        .m_ready_i  (m_ready_i)
    );

    // ========================================================================
    // Helpers
    // ========================================================================

    // Initial memory pattern over all address bits
    function automatic logic [7:0] fill_byte(input logic [11:0] a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;
    endfunction

    // Bit position of line byte i with word 0 at the top
    function automatic int line_bit(input int i);
        return (dcache_pkg::WORDS_PER_LINE - 1 - i / 4) * dcache_pkg::XLEN + 8 * (i % 4);
    endfunction

    function automatic dcache_pkg::line_t read_line(input logic from_gold,
                                                    input dcache_pkg::addr_t base);
        dcache_pkg::line_t result;
        logic [11:0]       a;
        result = '0;
        for (int i = 0; i < LINE_BYTES; i++)
        begin
            a = {base[11:4], 4'h0} + 12'(i);
            result[line_bit(i) +: 8] = from_gold ? gold_bytes[a] : mem_bytes[a];
        end
        return result;
    endfunction

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("error at %0d ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic fill_table();
        // Set 1 cycles through tags 0, 1 and 2
        stim[0]  = {1'b0, 4'h0, 32'h0000_0010, 32'h0000_0000, 1'b0};
        stim[1]  = {1'b1, 4'hf, 32'h0000_0014, 32'h1111_2222, 1'b1};
        stim[2]  = {1'b1, 4'h3, 32'h0000_0090, 32'haaaa_bbbb, 1'b0};
        stim[3]  = {1'b0, 4'h0, 32'h0000_0094, 32'h0000_0000, 1'b1};
        stim[4]  = {1'b0, 4'h0, 32'h0000_0118, 32'h0000_0000, 1'b0};
        stim[5]  = {1'b0, 4'h0, 32'h0000_0014, 32'h0000_0000, 1'b0};
        stim[6]  = {1'b1, 4'h8, 32'h0000_011c, 32'hcc00_0000, 1'b1};
        // Set 2 with two tags only
        stim[7]  = {1'b1, 4'h6, 32'h0000_0020, 32'h0055_6600, 1'b0};
        stim[8]  = {1'b0, 4'h0, 32'h0000_0020, 32'h0000_0000, 1'b1};
        stim[9]  = {1'b0, 4'h0, 32'h0000_00a4, 32'h0000_0000, 1'b0};
        // Set 5 with dirty evictions back to back
        stim[10] = {1'b1, 4'hf, 32'h0000_01d0, 32'h1234_5678, 1'b0};
        stim[11] = {1'b1, 4'h1, 32'h0000_025c, 32'h0000_009a, 1'b0};
        stim[12] = {1'b0, 4'h0, 32'h0000_02d8, 32'h0000_0000, 1'b0};
        stim[13] = {1'b0, 4'h0, 32'h0000_01d0, 32'h0000_0000, 1'b0};
        stim[14] = {1'b0, 4'h0, 32'h0000_025c, 32'h0000_0000, 1'b0};
        // Sets 1 and 2 again
        stim[15] = {1'b0, 4'h0, 32'h0000_0110, 32'h0000_0000, 1'b1};
        stim[16] = {1'b0, 4'h0, 32'h0000_0090, 32'h0000_0000, 1'b0};
        stim[17] = {1'b0, 4'h0, 32'h0000_011c, 32'h0000_0000, 1'b0};
        stim[18] = {1'b1, 4'hf, 32'h0000_00a8, 32'hdead_beef, 1'b1};
        stim[19] = {1'b0, 4'h0, 32'h0000_00a8, 32'h0000_0000, 1'b1};
    endtask

    // ========================================================================
    // One request from prediction to model update
    // ========================================================================

    task automatic run_entry(input stim_t s);
        dcache_pkg::cpu_req_t req;
        dcache_pkg::index_t   set_idx;
        dcache_pkg::tag_t     tag;
        dcache_pkg::addr_t    victim_addr;
        dcache_pkg::addr_t    line_addr;
        dcache_pkg::word_t    exp_word;
        dcache_pkg::word_t    rdata;
        logic [11:0]          a;
        logic                 evict_dirty;
        logic                 strobe_seen;
        int                   hit_slot;
        int                   n_mem;
        int                   lat;

        // Address split tag | index | word | byte
        set_idx   = s.addr[6:4];
        tag       = s.addr[31:7];
        line_addr = {s.addr[31:4], 4'h0};
        a         = {s.addr[11:2], 2'b00};
        exp_word  = {gold_bytes[a + 3], gold_bytes[a + 2], gold_bytes[a + 1], gold_bytes[a]};

        hit_slot = -1;
        for (int j = 0; j < way_count[set_idx]; j++)
            if (way_tag[set_idx][j] == tag)
                hit_slot = j;
        // Oldest line leaves a full set
        evict_dirty = 1'b0;
        victim_addr = '0;
        if (hit_slot < 0 && way_count[set_idx] == dcache_pkg::N_WAYS)
        begin
            evict_dirty = way_dirty[set_idx][0];
            victim_addr = {way_tag[set_idx][0], set_idx, 4'h0};
        end

        req.rw    = s.rw;
        req.be    = s.be;
        req.addr  = s.addr;
        req.wdata = s.wdata;
        @(posedge clk_i);
        p_strobe_i <= 1'b1;
        p_req_i    <= req;
        @(posedge clk_i);
        p_strobe_i <= 1'b0;
        lat         = 0;
        strobe_seen = 1'b0;
        // Outputs sampled mid-cycle
        do
        begin
            @(negedge clk_i);
            lat++;
            if (m_strobe_o)
                strobe_seen = 1'b1;
        end
        while (!p_ready_o);
        rdata = p_rdata_o;

        if (s.hit)
        begin
            check_value("p_ready_o latency", lat, 1);
            check_value("m_strobe_o", strobe_seen, 1'b0);
        end
        n_mem = s.hit ? 0 : (evict_dirty ? 2 : 1);
        check_value("memory transfers", log_rw.size(), n_mem);
        if (log_rw.size() == n_mem && n_mem > 0)
        begin
            if (evict_dirty)
            begin
                check_value("write-back m_req_o.rw", log_rw[0], 1'b1);
                check_value("write-back m_req_o.addr", log_addr[0], victim_addr);
                check_value("write-back m_req_o.wdata", log_data[0],
                            read_line(1'b1, victim_addr));
            end
            check_value("refill m_req_o.rw", log_rw[n_mem-1], 1'b0);
            check_value("refill m_req_o.addr", log_addr[n_mem-1], line_addr);
        end
        if (!s.rw)
            check_value("p_rdata_o", rdata, exp_word);
        log_rw.delete();
        log_addr.delete();
        log_data.delete();

        // Golden bytes follow every processor write
        if (s.rw)
        begin
            for (int b = 0; b < 4; b++)
                if (s.be[b])
                    gold_bytes[a + b] = s.wdata[8*b +: 8];
        end
        if (hit_slot >= 0)
            way_dirty[set_idx][hit_slot] = way_dirty[set_idx][hit_slot] | s.rw;
        else
        begin
            if (way_count[set_idx] == dcache_pkg::N_WAYS)
            begin
                way_tag[set_idx][0]   = way_tag[set_idx][1];
                way_dirty[set_idx][0] = way_dirty[set_idx][1];
                way_count[set_idx]    = 1;
            end
            way_tag[set_idx][way_count[set_idx]]   = tag;
            way_dirty[set_idx][way_count[set_idx]] = s.rw;
            way_count[set_idx]++;
        end
    endtask

    // ========================================================================
    // Clock, memory model, watchdog and main sequence
    // ========================================================================

    initial
    begin
        clk_i = 1'b0;
        forever
            #50 clk_i = ~clk_i;
    end

    initial
    begin : memory_model
        int unsigned       wait_left;
        dcache_pkg::addr_t base;
        dcache_pkg::line_t answer_line;
        logic              respond;
        m_ready_i = 1'b0;
        m_rdata_i = '0;
        wait_left = 0;
        void'($urandom(32'ha541));
        forever
        begin
            // Strobe and request looked at mid-cycle
            @(negedge clk_i);
            respond     = 1'b0;
            answer_line = m_rdata_i;
            if (!rst_i && m_strobe_o === 1'b1 && !m_ready_i)
            begin
                // New transfer draws 1 to 4 cycles
                if (wait_left == 0)
                    wait_left = $urandom % 4 + 1;
                wait_left--;
                if (wait_left == 0)
                begin
                    base = {m_req_o.addr[31:4], 4'h0};
                    log_rw.push_back(m_req_o.rw);
                    log_addr.push_back(m_req_o.addr);
                    log_data.push_back(m_req_o.wdata);
                    if (m_req_o.rw)
                    begin
                        for (int i = 0; i < LINE_BYTES; i++)
                            mem_bytes[base[11:0] + i] = m_req_o.wdata[line_bit(i) +: 8];
                    end
                    else
                        answer_line = read_line(1'b0, base);
                    respond = 1'b1;
                end
            end
            // Answer on the following rising edge
            @(posedge clk_i);
            m_ready_i <= respond;
            m_rdata_i <= answer_line;
        end
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk_i);
            cycle_count = cycle_count + 1;
        end
        $display("timeout after %0d cycles, a request never completed", cycle_count);
        $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        rst_i       = 1'b1;
        p_strobe_i  = 1'b0;
        p_req_i     = '0;
        check_count = 0;
        error_count = 0;
        for (int i = 0; i < MEM_BYTES; i++)
        begin
            gold_bytes[i] = fill_byte(12'(i));
            mem_bytes[i]  = fill_byte(12'(i));
        end
        for (int i = 0; i < dcache_pkg::N_SETS; i++)
            way_count[i] = 0;
        fill_table();

        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        for (int i = 0; i < N_ENTRIES; i++)
            run_entry(stim[i]);

        $display("%0d checks, %0d errors, %0d assertion failures",
                 check_count, error_count, DUT.u_sva.fail_count);
        if (error_count == 0 && DUT.u_sva.fail_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/10ps

module dcache_ctrl
(
    input  logic                              clk_i,
    input  logic                              rst_i,
    // Processor side
    input  logic                              p_strobe_i,
    input  dcache_pkg::cpu_req_t              p_req_i,
    output logic                              p_ready_o,
    // Memory side
    input  logic                              m_ready_i,
    input  dcache_pkg::line_t                 m_rdata_i,
    output dcache_pkg::mem_req_t              m_req_o,
    output logic                              m_strobe_o,
    // Array control
    output dcache_pkg::index_t                lookup_index_o,
    output dcache_pkg::cpu_req_t              req_q_o,
    input  logic                              hit_i,
    input  dcache_pkg::way_t                  hit_way_i,
    input  dcache_pkg::way_t                  victim_way_i,
    input  logic                              victim_dirty_i,
    input  dcache_pkg::tag_t                  victim_tag_i,
    input  dcache_pkg::line_t                 rd_line_i,
    output logic                              fill_o,
    output logic                              hit_write_o,
    output logic [dcache_pkg::N_WAYS-1:0]     line_we_o,
    output dcache_pkg::way_t                  rd_way_o,
    output logic                              use_refill_o,
    output dcache_pkg::line_t                 refill_line_o
);

    localparam int LINE_LSB = dcache_pkg::BYTE_BITS + dcache_pkg::OFFSET_BITS;

    dcache_pkg::cache_state_e state_q;
    dcache_pkg::cache_state_e state_d;
    dcache_pkg::cpu_req_t     req_q;
    dcache_pkg::index_t       req_index;
    dcache_pkg::mem_req_t     wb_req;
    dcache_pkg::mem_req_t     fill_req;
    dcache_pkg::mem_req_t     m_req_q;
    dcache_pkg::line_t        refill_q;
    logic                     m_strobe_q;

    assign req_index = req_q.addr[LINE_LSB +: dcache_pkg::INDEX_BITS];

    // Live index at the strobe edge, held index afterwards
    assign lookup_index_o = (state_q == dcache_pkg::S_IDLE)
                          ? p_req_i.addr[LINE_LSB +: dcache_pkg::INDEX_BITS]
                          : req_index;

    // ========================================================================
    // State machine
    // ========================================================================

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= dcache_pkg::S_IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::S_IDLE:
                if (p_strobe_i)
                    state_d = dcache_pkg::S_LOOKUP;
            dcache_pkg::S_LOOKUP:
                // Miss goes through write-back only for a dirty victim
                if (hit_i)
                    state_d = dcache_pkg::S_IDLE;
                else if (victim_dirty_i)
                    state_d = dcache_pkg::S_WRITE_BACK;
                else
                    state_d = dcache_pkg::S_REFILL;
            dcache_pkg::S_WRITE_BACK:
                if (m_ready_i)
                    state_d = dcache_pkg::S_REFILL;
            dcache_pkg::S_REFILL:
                if (m_ready_i)
                    state_d = dcache_pkg::S_REFILL_DONE;
            default:
                state_d = dcache_pkg::S_IDLE;
        endcase
    end

    // Request capture, one request in flight
    always_ff @(posedge clk_i)
    begin
        if (state_q == dcache_pkg::S_IDLE && p_strobe_i)
            req_q <= p_req_i;
    end

    assign req_q_o = req_q;

    // ========================================================================
    // Memory port
    // ========================================================================

    // Victim line back to its own line address
    always_comb
    begin
        wb_req.rw      = 1'b1;
        wb_req.addr    = {victim_tag_i, req_index, {LINE_LSB{1'b0}}};
        wb_req.wdata   = rd_line_i;
        fill_req.rw    = 1'b0;
        fill_req.addr  = {req_q.addr[dcache_pkg::XLEN-1:LINE_LSB], {LINE_LSB{1'b0}}};
        fill_req.wdata = '0;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            m_strobe_q <= 1'b0;
        else if (state_q == dcache_pkg::S_LOOKUP && !hit_i)
            m_strobe_q <= 1'b1;
        else if (m_ready_i)
            m_strobe_q <= 1'b0;
        // Refill after a write-back starts one idle cycle later
        else if (state_q == dcache_pkg::S_REFILL && !m_strobe_q)
            m_strobe_q <= 1'b1;
    end

    // Request is loaded while the strobe is low or being raised
    always_ff @(posedge clk_i)
    begin
        if (state_q == dcache_pkg::S_LOOKUP && !hit_i)
            m_req_q <= victim_dirty_i ? wb_req : fill_req;
        else if (state_q == dcache_pkg::S_WRITE_BACK && m_ready_i)
            m_req_q <= fill_req;
    end

    // Refill line capture
    always_ff @(posedge clk_i)
    begin
        if (state_q == dcache_pkg::S_REFILL && m_ready_i)
            refill_q <= m_rdata_i;
    end

    assign m_strobe_o    = m_strobe_q;
    assign m_req_o       = m_req_q;
    assign refill_line_o = refill_q;

    // ========================================================================
    // Array updates and processor handshake
    // ========================================================================

    assign hit_write_o  = (state_q == dcache_pkg::S_LOOKUP) && hit_i && req_q.rw;
    assign fill_o       = (state_q == dcache_pkg::S_REFILL_DONE);
    assign use_refill_o = (state_q == dcache_pkg::S_REFILL_DONE);
    assign rd_way_o     = hit_i ? hit_way_i : victim_way_i;
    assign p_ready_o    = ((state_q == dcache_pkg::S_LOOKUP) && hit_i) || fill_o;

    always_comb
    begin
        line_we_o = '0;
        if (hit_write_o)
            line_we_o[hit_way_i] = 1'b1;
        else if (fill_o)
            line_we_o[victim_way_i] = 1'b1;
    end

endmodule

// ==== verilog/dcache_data_array.sv ====
`timescale 1ns/10ps

module dcache_data_array
(
    input  logic                            clk_i,
    input  dcache_pkg::index_t              lookup_index_i,
    input  logic [dcache_pkg::N_WAYS-1:0]   line_we_i,
    input  dcache_pkg::line_t               wr_line_i,
    input  dcache_pkg::way_t                rd_way_i,
    output dcache_pkg::line_t               rd_line_o
);

    // ========================================================================
    // Line storage
    // ========================================================================

    dcache_pkg::line_t rd_q [dcache_pkg::N_WAYS];

    for (genvar w = 0; w < dcache_pkg::N_WAYS; w++)
    begin : g_way
        dcache_pkg::line_t line_mem [dcache_pkg::N_SETS];

        // Write and read share the lookup index
        always_ff @(posedge clk_i)
        begin
            if (line_we_i[w])
                line_mem[lookup_index_i] <= wr_line_i;
            rd_q[w] <= line_mem[lookup_index_i];
        end
    end

    // Way select after the registered read
    assign rd_line_o = rd_q[rd_way_i];

endmodule

// ==== verilog/dcache_merge.sv ====
`timescale 1ns/10ps

module dcache_merge
(
    input  dcache_pkg::line_t     base_line_i,
    input  dcache_pkg::line_t     refill_line_i,
    input  logic                  use_refill_i,
    input  dcache_pkg::cpu_req_t  req_i,
    output dcache_pkg::word_t     word_o,
    output dcache_pkg::line_t     new_line_o
);

    localparam int XLEN   = dcache_pkg::XLEN;
    localparam int N_BYTE = XLEN / 8;

    dcache_pkg::offset_t offset;
    dcache_pkg::line_t   src_line;
    dcache_pkg::word_t   src_word;
    dcache_pkg::word_t   merged;
    int unsigned         word_lsb;

    assign offset = req_i.addr[dcache_pkg::BYTE_BITS +: dcache_pkg::OFFSET_BITS];

    always_comb
    begin
        // Refill line on a miss, array line on a hit
        src_line = use_refill_i ? refill_line_i : base_line_i;
        // Word 0 at the top of the line
        word_lsb = (dcache_pkg::WORDS_PER_LINE - 1 - int'(offset)) * XLEN;
        src_word = src_line[word_lsb +: XLEN];

        // Per-byte replace under the byte enables
        merged = src_word;
        for (int b = 0; b < N_BYTE; b++)
        begin
            if (req_i.be[b])
                merged[8*b +: 8] = req_i.wdata[8*b +: 8];
        end

        new_line_o = src_line;
        if (req_i.rw)
            new_line_o[word_lsb +: XLEN] = merged;
    end

    assign word_o = src_word;

endmodule

// ==== verilog/dcache_pkg.sv ====
package dcache_pkg;

    // ========================================================================
    // Cache geometry
    // ========================================================================

    // Word and line sizes
    localparam int XLEN           = 32;
    localparam int N_WAYS         = 2;
    localparam int N_SETS         = 8;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_BITS      = XLEN * WORDS_PER_LINE;

    // Address split, tag | index | word offset | byte offset
    localparam int BYTE_BITS      = 2;
    localparam int OFFSET_BITS    = 2;
    localparam int INDEX_BITS     = 3;
    localparam int TAG_BITS       = XLEN - INDEX_BITS - OFFSET_BITS - BYTE_BITS;

    // ========================================================================
    // Vector types
    // ========================================================================

    typedef logic [XLEN-1:0]              addr_t;
    typedef logic [XLEN-1:0]              word_t;
    // Word 0 sits in the top bits of a line
    typedef logic [LINE_BITS-1:0]         line_t;
    typedef logic [XLEN/8-1:0]            be_t;
    typedef logic [TAG_BITS-1:0]          tag_t;
    typedef logic [INDEX_BITS-1:0]        index_t;
    typedef logic [OFFSET_BITS-1:0]       offset_t;
    typedef logic [$clog2(N_WAYS)-1:0]    way_t;

    // ========================================================================
    // Request bundles
    // ========================================================================

    // Processor request, rw high for a write
    typedef struct packed {
        logic  rw;
        be_t   be;
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    // Memory request, a whole line per transfer
    typedef struct packed {
        logic  rw;
        addr_t addr;
        line_t wdata;
    } mem_req_t;

    // Controller states
    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WRITE_BACK,
        S_REFILL,
        S_REFILL_DONE
    } cache_state_e;

endpackage

// ==== verilog/dcache_tag_array.sv ====
`timescale 1ns/10ps

module dcache_tag_array
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  dcache_pkg::index_t    lookup_index_i,
    input  dcache_pkg::cpu_req_t  req_i,
    input  logic                  fill_i,
    input  logic                  hit_write_i,
    output logic                  hit_o,
    output dcache_pkg::way_t      hit_way_o,
    output dcache_pkg::way_t      victim_way_o,
    output logic                  victim_dirty_o,
    output dcache_pkg::tag_t      victim_tag_o
);

    localparam int N_WAYS   = dcache_pkg::N_WAYS;
    localparam int LINE_LSB = dcache_pkg::BYTE_BITS + dcache_pkg::OFFSET_BITS;
    localparam int TAG_LSB  = LINE_LSB + dcache_pkg::INDEX_BITS;

    dcache_pkg::index_t   req_set;
    dcache_pkg::tag_t     req_tag;
    dcache_pkg::tag_t     tag_q [N_WAYS];
    logic [N_WAYS-1:0]    valid_q [dcache_pkg::N_SETS];
    logic [N_WAYS-1:0]    dirty_q [dcache_pkg::N_SETS];
    dcache_pkg::way_t     fifo_q [dcache_pkg::N_SETS];
    logic [N_WAYS-1:0]    way_hit;
    dcache_pkg::way_t     hit_way;
    dcache_pkg::way_t     victim;

    assign req_set = req_i.addr[LINE_LSB +: dcache_pkg::INDEX_BITS];
    assign req_tag = req_i.addr[TAG_LSB +: dcache_pkg::TAG_BITS];
    assign victim  = fifo_q[req_set];

    // ========================================================================
    // Tag storage, one RAM per way
    // ========================================================================

    for (genvar w = 0; w < N_WAYS; w++)
    begin : g_way
        dcache_pkg::tag_t tag_mem [dcache_pkg::N_SETS];

        // Refill writes the victim way of the request set
        always_ff @(posedge clk_i)
        begin
            if (fill_i && victim == w)
                tag_mem[req_set] <= req_tag;
            tag_q[w] <= tag_mem[lookup_index_i];
        end

        assign way_hit[w] = valid_q[req_set][w] && (tag_q[w] == req_tag);
    end

    // Valid, dirty and FIFO pointer per set
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < dcache_pkg::N_SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                fifo_q[s]  <= '0;
            end
        end
        else if (fill_i)
        begin
            valid_q[req_set][victim] <= 1'b1;
            dirty_q[req_set][victim] <= req_i.rw;
            fifo_q[req_set]          <= dcache_pkg::way_t'(victim + 1'b1);
        end
        else if (hit_write_i)
            dirty_q[req_set][hit_way] <= 1'b1;
    end

    // Hit way encode, at most one way matches
    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < N_WAYS; w++)
        begin
            if (way_hit[w])
                hit_way = dcache_pkg::way_t'(w);
        end
    end

    assign hit_o          = |way_hit;
    assign hit_way_o      = hit_way;
    assign victim_way_o   = victim;
    assign victim_dirty_o = dirty_q[req_set][victim];
    assign victim_tag_o   = tag_q[victim];

endmodule

// ==== verilog/dcache_top.sv ====
`timescale 1ns/10ps

module dcache_top
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    // Processor port
    input  logic                  p_strobe_i,
    input  dcache_pkg::cpu_req_t  p_req_i,
    output dcache_pkg::word_t     p_rdata_o,
    output logic                  p_ready_o,
    // Memory port
    output dcache_pkg::mem_req_t  m_req_o,
    output logic                  m_strobe_o,
    input  dcache_pkg::line_t     m_rdata_i,
    input  logic                  m_ready_i
);

    // ========================================================================
    // Internal wiring
    // ========================================================================

    dcache_pkg::index_t                 lookup_index;
    dcache_pkg::cpu_req_t               req_q;
    logic                               hit;
    dcache_pkg::way_t                   hit_way;
    dcache_pkg::way_t                   victim_way;
    logic                               victim_dirty;
    dcache_pkg::tag_t                   victim_tag;
    dcache_pkg::line_t                  rd_line;
    dcache_pkg::line_t                  refill_line;
    dcache_pkg::line_t                  new_line;
    logic                               fill;
    logic                               hit_write;
    logic [dcache_pkg::N_WAYS-1:0]      line_we;
    dcache_pkg::way_t                   rd_way;
    logic                               use_refill;

    // Controller
    dcache_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .p_strobe_i     (p_strobe_i),
        .p_req_i        (p_req_i),
        .p_ready_o      (p_ready_o),
        .m_ready_i      (m_ready_i),
        .m_rdata_i      (m_rdata_i),
        .m_req_o        (m_req_o),
        .m_strobe_o     (m_strobe_o),
        .lookup_index_o (lookup_index),
        .req_q_o        (req_q),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .rd_line_i      (rd_line),
        .fill_o         (fill),
        .hit_write_o    (hit_write),
        .line_we_o      (line_we),
        .rd_way_o       (rd_way),
        .use_refill_o   (use_refill),
        .refill_line_o  (refill_line)
    );

    // Tags, valid, dirty and FIFO state
    dcache_tag_array u_tag_array (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .lookup_index_i (lookup_index),
        .req_i          (req_q),
        .fill_i         (fill),
        .hit_write_i    (hit_write),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    // Line storage
    dcache_data_array u_data_array (
        .clk_i          (clk_i),
        .lookup_index_i (lookup_index),
        .line_we_i      (line_we),
        .wr_line_i      (new_line),
        .rd_way_i       (rd_way),
        .rd_line_o      (rd_line)
    );

    // Word read-out and write merge
    dcache_merge u_merge (
        .base_line_i    (rd_line),
        .refill_line_i  (refill_line),
        .use_refill_i   (use_refill),
        .req_i          (req_q),
        .word_o         (p_rdata_o),
        .new_line_o     (new_line)
    );

endmodule
